/* common/multPkg.sv */
// Shared widths and operand types for the 8-bit signed shift-and-add multiplier
`default_nettype none

package multPkg;

    // Operand width, one switch word
    localparam int operandWidth = 8;

    // One add/shift pair per multiplier bit
    localparam int bitSteps = 8;

    // Enough to index bitSteps bits
    localparam int countWidth = 3;

    // Signed operand as seen on the switches, A and B
    typedef logic signed [operandWidth-1:0] operandT;

    // Sign-extended sum, top bit becomes X
    typedef logic signed [operandWidth:0] extT;

endpackage

`default_nettype wire

/* common/datapathCtrlIf.sv */
// Control strobes from the sequencer to the product register, plus the current multiplier bit
`timescale 1ns/1ps
`default_nettype none

interface datapathCtrlIf;

    logic clrLd;   // Load B from Sw, clear X and A
    logic clearA;  // Clear X and A only
    logic shift;   // Arithmetic shift of X, A, B
    logic add;     // Capture A + S
    logic sub;     // Capture A - S, sign bit step
    logic m;       // B bit 0

    // Sequencer side
    modport control (
        output clrLd,
        output clearA,
        output shift,
        output add,
        output sub,
        input  m
    );

    // Register side
    modport datapath (
        input  clrLd,
        input  clearA,
        input  shift,
        input  add,
        input  sub,
        output m
    );

endinterface

`default_nettype wire

/* src/bitCounter.sv */
// Multiplier bit counter, flags the sign bit step
`timescale 1ns/1ps
`default_nettype none

module bitCounter (
    input  logic Clk,
    input  logic rstN,
    input  logic countClear,
    input  logic countStep,
    output logic lastBit
);

    logic [multPkg::countWidth-1:0] count;

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            count <= '0;
        end
        else if (countClear)
        begin
            count <= '0;
        end
        else if (countStep)
        begin
            count <= count + 1'b1;  // Wraps back to 0 after the sign bit
        end
    end

    // High while bit 7 is being worked on
    assign lastBit = (count == multPkg::countWidth'(multPkg::bitSteps - 1));

endmodule

`default_nettype wire

/* src/multControl.sv */
// Multiplier sequencer, a Moore FSM stepping clear, add/subtract and shift
// with a separate bit counter in place of unrolled per-bit states
`timescale 1ns/1ps
`default_nettype none

module multControl (
    input  logic Clk,
    input  logic rstN,
    input  logic Run,
    input  logic ClearALoadB,
    input  logic lastBit,
    output logic countClear,
    output logic countStep,
    datapathCtrlIf.control ctrl
);

    typedef enum logic [2:0] {
        Idle,
        Clear,
        Add,
        Shift,
        Done
    } stateT;

    stateT state;
    stateT nextState;

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= Idle;
        end
        else
        begin
            state <= nextState;
        end
    end

    // Next state
    always_comb
    begin
        nextState = state;
        unique case (state)
            Idle:
            begin
                if (Run)
                begin
                    nextState = Clear;
                end
            end
            Clear: nextState = Add;  // Bit 0 next
            Add:   nextState = Shift;
            Shift:
            begin
                // Sign bit was the last one processed
                if (lastBit)
                begin
                    nextState = Done;
                end
                else
                begin
                    nextState = Add;
                end
            end
            Done:
            begin
                if (!Run)
                begin
                    nextState = Idle;  // Run must drop before another multiply
                end
            end
            default: nextState = Idle;
        endcase
    end

    // Strobes, all one-cycle levels
    always_comb
    begin
        ctrl.clrLd  = 1'b0;
        ctrl.clearA = 1'b0;
        ctrl.shift  = 1'b0;
        ctrl.add    = 1'b0;
        ctrl.sub    = 1'b0;
        countClear  = 1'b0;
        countStep   = 1'b0;
        unique case (state)
            Idle, Done:
            begin
                ctrl.clrLd = ClearALoadB;  // Reload only while not multiplying
            end
            Clear:
            begin
                ctrl.clearA = 1'b1;
                countClear  = 1'b1;
            end
            Add:
            begin
                // Subtract S for the sign bit, add for the rest
                ctrl.add = ctrl.m & ~lastBit;
                ctrl.sub = ctrl.m & lastBit;
            end
            Shift:
            begin
                ctrl.shift = 1'b1;
                countStep  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* datapath/addSubUnit.sv */
// Ripple-carry adder/subtractor forming A plus or minus S at nine bits
`timescale 1ns/1ps
`default_nettype none

module addSubUnit (
    input  multPkg::operandT a,
    input  multPkg::operandT s,
    input  logic             sub,
    output multPkg::extT     sum
);

    localparam int msb = multPkg::operandWidth - 1;

    multPkg::extT aExt;
    multPkg::extT sExt;
    multPkg::extT sOp;
    logic [multPkg::operandWidth:0] carry;

    assign aExt = {a[msb], a};
    assign sExt = {s[msb], s};

    // Two's complement subtract: invert S and carry in a 1
    assign sOp      = sExt ^ {(multPkg::operandWidth + 1){sub}};
    assign carry[0] = sub;

    genvar i;
    generate
        for (i = 0; i < multPkg::operandWidth; i++)
        begin : gFullAdd
            assign sum[i]     = aExt[i] ^ sOp[i] ^ carry[i];
            assign carry[i+1] = (aExt[i] & sOp[i]) | (carry[i] & (aExt[i] ^ sOp[i]));
        end
    endgenerate

    // Ninth cell, carry out is not needed
    assign sum[multPkg::operandWidth] = aExt[multPkg::operandWidth] ^
                                        sOp[multPkg::operandWidth] ^
                                        carry[multPkg::operandWidth];

endmodule

`default_nettype wire

/* datapath/productRegister.sv */
// X, A and B registers holding the partial product and the multiplier
`timescale 1ns/1ps
`default_nettype none

module productRegister (
    input  logic             Clk,
    input  logic             rstN,
    input  multPkg::operandT Sw,
    datapathCtrlIf.datapath  ctrl,
    input  multPkg::extT     sum,
    output multPkg::operandT aReg,
    output multPkg::operandT bReg,
    output logic             xBit
);

    localparam int msb = multPkg::operandWidth - 1;

    always_ff @(posedge Clk or negedge rstN)
    begin
        if (!rstN)
        begin
            xBit <= 1'b0;
            aReg <= '0;
            bReg <= '0;
        end
        else if (ctrl.clrLd)
        begin
            // New multiplier from the switches
            xBit <= 1'b0;
            aReg <= '0;
            bReg <= Sw;
        end
        else if (ctrl.clearA)
        begin
            xBit <= 1'b0;
            aReg <= '0;
        end
        else if (ctrl.add || ctrl.sub)
        begin
            {xBit, aReg} <= sum;  // Ninth bit keeps the sign on overflow
        end
        else if (ctrl.shift)
        begin
            // X copies into itself, A bit 0 drops into B
            {xBit, aReg, bReg} <= {xBit, xBit, aReg, bReg[msb:1]};
        end
    end

    assign ctrl.m = bReg[0];  // Current multiplier bit

endmodule

`default_nettype wire

/* src/multiplierTop.sv */
// 8-bit signed shift-and-add multiplier top level
// Product ends in A (high byte) and B (low byte), X holds its sign
`timescale 1ns/1ps
`default_nettype none

module multiplierTop (
    input  logic             Clk,
    input  logic             rstN,
    input  logic             Run,
    input  logic             ClearALoadB,
    input  multPkg::operandT Sw,
    output multPkg::operandT Aval,
    output multPkg::operandT Bval,
    output logic             X
);

    logic countClear;
    logic countStep;
    logic lastBit;

    multPkg::extT sum;

    datapathCtrlIf ctrlBus ();

    multControl multControl_i (
        .Clk         (Clk),
        .rstN        (rstN),
        .Run         (Run),
        .ClearALoadB (ClearALoadB),
        .lastBit     (lastBit),
        .countClear  (countClear),
        .countStep   (countStep),
        .ctrl        (ctrlBus.control)
    );

    bitCounter bitCounter_i (
        .Clk        (Clk),
        .rstN       (rstN),
        .countClear (countClear),
        .countStep  (countStep),
        .lastBit    (lastBit)
    );

    // Switches act as S during the multiply
    addSubUnit addSubUnit_i (
        .a   (Aval),
        .s   (Sw),
        .sub (ctrlBus.sub),
        .sum (sum)
    );

    productRegister productRegister_i (
        .Clk  (Clk),
        .rstN (rstN),
        .Sw   (Sw),
        .ctrl (ctrlBus.datapath),
        .sum  (sum),
        .aReg (Aval),
        .bReg (Bval),
        .xBit (X)
    );

endmodule

`default_nettype wire

/* verification/multiplierTb.sv */
// Testbench for the 8-bit signed shift-and-add multiplier
// Directed and random multiplies checked against a signed product model
`timescale 1ns/1ps
`default_nettype none

module multiplierTb;

    localparam int productWidth = 2 * multPkg::operandWidth;
    localparam int randomPairs = 30;
    localparam int multiplyCount = 6 + randomPairs + 4;  // Directed, random, Run hold, reload
    localparam int watchdogCycles = multiplyCount * 200 + 200;
    localparam int productCycles = 18;  // Edges from Run drive to final shift

    logic Clk;
    logic rstN;
    logic Run;
    logic ClearALoadB;
    multPkg::operandT Sw;
    multPkg::operandT Aval;
    multPkg::operandT Bval;
    logic X;

    int errorCount;
    int checkCount;
    logic [31:0] rngState;

    multiplierTop multiplierTop_i (
        .Clk         (Clk),
        .rstN        (rstN),
        .Run         (Run),
        .ClearALoadB (ClearALoadB),
        .Sw          (Sw),
        .Aval        (Aval),
        .Bval        (Bval),
        .X           (X)
    );

    initial
    begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // Signed product of two operands, widened before multiplying
    function automatic logic signed [productWidth-1:0] refProduct(input multPkg::operandT s,
                                                                  input multPkg::operandT b);
        logic signed [productWidth-1:0] sWide;
        logic signed [productWidth-1:0] bWide;
        sWide = {{multPkg::operandWidth{s[multPkg::operandWidth-1]}}, s};
        bWide = {{multPkg::operandWidth{b[multPkg::operandWidth-1]}}, b};
        return sWide * bWide;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic checkOperand(input string what, input multPkg::operandT got,
                                input multPkg::operandT expected);
        checkCount++;
        if (got !== expected)
        begin
            errorCount++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic checkBit(input string what, input logic got, input logic expected);
        checkCount++;
        if (got !== expected)
        begin
            errorCount++;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    // Pulse ClearALoadB for one cycle, then expect B loaded and A, X cleared
    task automatic loadB(input multPkg::operandT b);
        @(posedge Clk);
        Sw          <= b;
        ClearALoadB <= 1'b1;
        @(posedge Clk);
        ClearALoadB <= 1'b0;
        @(negedge Clk);
        checkOperand("Bval after load", Bval, b);
        checkOperand("Aval after load", Aval, '0);
        checkBit("X after load", X, 1'b0);
    endtask

    // Raise Run with S on the switches, check the product 18 edges later, Run stays high
    task automatic multiply(input multPkg::operandT s, input multPkg::operandT b,
                            output logic signed [productWidth-1:0] product);
        product = refProduct(s, b);
        @(posedge Clk);
        Sw  <= s;
        Run <= 1'b1;
        repeat (productCycles) @(posedge Clk);
        @(negedge Clk);
        checkOperand("Aval product high", Aval, product[productWidth-1:multPkg::operandWidth]);
        checkOperand("Bval product low", Bval, product[multPkg::operandWidth-1:0]);
        checkBit("X product sign", X, product[productWidth-1]);
    endtask

    // Drop Run and give Done one edge to fall back to Idle
    task automatic releaseRun();
        @(posedge Clk);
        Run <= 1'b0;
        repeat (2) @(posedge Clk);
    endtask

    task automatic productCase(input multPkg::operandT s, input multPkg::operandT b);
        logic signed [productWidth-1:0] product;
        loadB(b);
        multiply(s, b, product);
        releaseRun();
    endtask

    task automatic idleAfterReset();
        @(negedge Clk);
        checkOperand("Aval after reset", Aval, '0);
        checkOperand("Bval after reset", Bval, '0);
        checkBit("X after reset", X, 1'b0);
    endtask

    // Run stays low, so neither a new B nor a product may appear
    task automatic holdRunLow(input multPkg::operandT b);
        @(posedge Clk);
        Sw <= ~b;
        repeat (20) @(posedge Clk);
        @(negedge Clk);
        checkOperand("Aval with Run low", Aval, '0);
        checkOperand("Bval with Run low", Bval, b);
        checkBit("X with Run low", X, 1'b0);
    endtask

    task automatic directedProducts();
        productCase(8'sd25, 8'sd13);
        productCase(-8'sd83, 8'sd59);
        productCase(8'sd117, -8'sd24);
        productCase(-8'sd7, -8'sd102);
        productCase(8'sh80, 8'sh80);  // -128 squared
        productCase(8'sd0, -8'sd55);
    endtask

    task automatic randomProducts();
        multPkg::operandT s;
        multPkg::operandT b;
        for (int i = 0; i < randomPairs; i++)
        begin
            rngState = xorshift32(rngState);
            s = rngState[7:0];
            b = rngState[15:8];
            productCase(s, b);
        end
    endtask

    task automatic runHeldHigh();
        logic signed [productWidth-1:0] first;
        logic signed [productWidth-1:0] second;
        loadB(-8'sd61);
        multiply(8'sd93, -8'sd61, first);
        repeat (10) @(posedge Clk);
        @(negedge Clk);
        // Done must hold the product while Run stays high
        checkOperand("Aval with Run held", Aval, first[productWidth-1:multPkg::operandWidth]);
        checkOperand("Bval with Run held", Bval, first[multPkg::operandWidth-1:0]);
        checkBit("X with Run held", X, first[productWidth-1]);
        releaseRun();
        // No reload, so B is the low byte of the last product
        multiply(8'sd11, first[multPkg::operandWidth-1:0], second);
        releaseRun();
    endtask

    task automatic reloadInDone();
        logic signed [productWidth-1:0] product;
        loadB(8'sd77);
        multiply(-8'sd100, 8'sd77, product);  // Negative result leaves X and A set
        loadB(8'sd45);
        releaseRun();
        multiply(-8'sd19, 8'sd45, product);
        releaseRun();
    endtask

    // Watchdog
    initial
    begin
        repeat (watchdogCycles) @(posedge Clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", watchdogCycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        errorCount  = 0;
        checkCount  = 0;
        rngState    = 32'hdad0;
        rstN        = 1'b0;
        Run         = 1'b0;
        ClearALoadB = 1'b0;
        Sw          = '0;
        repeat (10) @(posedge Clk);
        rstN <= 1'b1;

        idleAfterReset();
        loadB(8'sh5a);
        holdRunLow(8'sh5a);
        directedProducts();
        randomProducts();
        runHeldHigh();
        reloadInDone();

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
common/multPkg.sv
common/datapathCtrlIf.sv
src/bitCounter.sv
src/multControl.sv
datapath/addSubUnit.sv
datapath/productRegister.sv
src/multiplierTop.sv
verification/multiplierTb.sv

/* run.sh */
#!/bin/sh
# Compile the multiplier and its testbench with Verilator, then run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module multiplierTb -f files.f -o simMultiplier
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/simMultiplier)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^PASS: all tests$'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
